//--- design/soc_pkg.sv
package soc_pkg;

	// Bus widths
	localparam int ARCH_BITS = 32;
	localparam int SEL_BITS = 4;
	localparam int ADDR_BITS = 30;

	typedef enum logic [1:0] {
		PI1_NOP  = 2'd0,
		PI1_WR   = 2'd1,
		PI1_RD   = 2'd2,
		PI1_RDWR = 2'd3
	} pi1_op_e;

	// Slaves in address order
	typedef enum logic [1:0] {
		SLV_INTCTRL = 2'd0,
		SLV_DEVTBL  = 2'd1,
		SLV_RAM     = 2'd2,
		SLV_INVALID = 2'd3
	} slave_idx_e;

	localparam int SLAVE_COUNT = 4;

	// Map sizes in words
	localparam int MAPSZ_INTCTRL = 4;
	localparam int MAPSZ_DEVTBL = 16;
	localparam int MAPSZ_RAM = 256;
	localparam int MAPSZ_INVALID = 1024;

	localparam int BASE_INTCTRL = 0;
	localparam int BASE_DEVTBL = BASE_INTCTRL + MAPSZ_INTCTRL;
	localparam int BASE_RAM = BASE_DEVTBL + MAPSZ_DEVTBL;
	localparam int BASE_INVALID = BASE_RAM + MAPSZ_RAM;

	localparam int DEVID_INTCTRL = 3;
	localparam int DEVID_DEVTBL = 7;
	localparam int DEVID_RAM = 1;
	localparam int DEVID_INVALID = 0;

	// None of the bus slaves raises an interrupt
	localparam logic [SLAVE_COUNT-1:0] USEINTR = '0;

	localparam int DEVTBL_CTRL_WORD = 8;

	localparam int INT_SRC_COUNT = 2;
	localparam int INT_IDX_BITS = $clog2(INT_SRC_COUNT);
	localparam int RAM_IDX_BITS = $clog2(MAPSZ_RAM);

	typedef enum logic [1:0] {
		IC_IDLE,
		IC_DELIVER,
		IC_ACK
	} ic_state_e;

	localparam int RST_CNTR_BITS = 4;
	localparam int RST_STRETCH = 15;

endpackage

//--- design/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic rst_req0_i,
	input  logic rst_req1_i,
	output logic sys_rst_o,
	output logic powered_off_o
);
	import soc_pkg::*;

	logic [RST_CNTR_BITS-1:0] cntr_q;
	logic rst_p_q;
	logic pwr_off_q;
	logic warm_req;
	logic pwr_off_req;

	// Cold reset (both bits) falls back to a warm reset
	assign warm_req = rst_req1_i;
	assign pwr_off_req = rst_req0_i && !rst_req1_i;

	// Delayed rst_p keeps the count full on the first edge out of reset
	always_ff @(posedge clk48mhz_i) begin
		rst_p_q <= rst_p;
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			cntr_q <= RST_CNTR_BITS'(RST_STRETCH);
		end else if (rst_p_q || warm_req) begin
			cntr_q <= RST_CNTR_BITS'(RST_STRETCH);
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// Power-off holds until the next external reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (pwr_off_req) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p || (cntr_q != '0) || pwr_off_q;
	assign powered_off_o = pwr_off_q;

endmodule

//--- design/pi1_router.sv
`timescale 1ns/1ps

module pi1_router (
	input  logic                         sys_rst_i,

	// Master side
	input  soc_pkg::pi1_op_e             op_i,
	input  logic [soc_pkg::ADDR_BITS-1:0] addr_i,
	input  logic [soc_pkg::ARCH_BITS-1:0] data_i,
	input  logic [soc_pkg::SEL_BITS-1:0]  sel_i,
	output logic [soc_pkg::ARCH_BITS-1:0] data_o,
	output logic                         rdy_o,

	// Slave side
	output soc_pkg::pi1_op_e             intc_op_o,
	output soc_pkg::pi1_op_e             devtbl_op_o,
	output soc_pkg::pi1_op_e             ram_op_o,
	output logic [soc_pkg::ADDR_BITS-1:0] slv_addr_o,
	output logic [soc_pkg::ARCH_BITS-1:0] slv_data_o,
	output logic [soc_pkg::SEL_BITS-1:0]  slv_sel_o,
	input  logic [soc_pkg::ARCH_BITS-1:0] intc_data_i,
	input  logic [soc_pkg::ARCH_BITS-1:0] devtbl_data_i,
	input  logic [soc_pkg::ARCH_BITS-1:0] ram_data_i
);
	import soc_pkg::*;

	slave_idx_e sel_idx;
	logic [ADDR_BITS-1:0] base;
	logic below_devtbl;
	logic below_ram;
	logic below_invalid;
	logic bus_en;

	// Region boundaries come straight from the package map
	assign below_devtbl = addr_i < ADDR_BITS'(BASE_DEVTBL);
	assign below_ram = addr_i < ADDR_BITS'(BASE_RAM);
	assign below_invalid = addr_i < ADDR_BITS'(BASE_INVALID);

	always_comb begin
		if (below_devtbl) begin
			sel_idx = SLV_INTCTRL;
			base = ADDR_BITS'(BASE_INTCTRL);
		end else if (below_ram) begin
			sel_idx = SLV_DEVTBL;
			base = ADDR_BITS'(BASE_DEVTBL);
		end else if (below_invalid) begin
			sel_idx = SLV_RAM;
			base = ADDR_BITS'(BASE_RAM);
		end else begin
			// Everything from the invalid base upward, past its end too
			sel_idx = SLV_INVALID;
			base = ADDR_BITS'(BASE_INVALID);
		end
	end

	// Nothing reaches a slave while the system sits in reset
	assign bus_en = !sys_rst_i;

	// All slaves answer in the request cycle
	assign rdy_o = bus_en;

	assign slv_addr_o = addr_i - base;
	assign slv_data_o = data_i;
	assign slv_sel_o = sel_i;

	always_comb begin
		intc_op_o = PI1_NOP;
		devtbl_op_o = PI1_NOP;
		ram_op_o = PI1_NOP;
		if (bus_en) begin
			case (sel_idx)
				SLV_INTCTRL: intc_op_o = op_i;
				SLV_DEVTBL: devtbl_op_o = op_i;
				SLV_RAM: ram_op_o = op_i;
				default: begin
					// Invalid device drops writes
				end
			endcase
		end
	end

	// Read data return, invalid device reads as zero
	always_comb begin
		case (sel_idx)
			SLV_INTCTRL: data_o = intc_data_i;
			SLV_DEVTBL: data_o = devtbl_data_i;
			SLV_RAM: data_o = ram_data_i;
			default: data_o = '0;
		endcase
	end

endmodule

//--- design/dev_table.sv
`timescale 1ns/1ps

module dev_table (
	input  soc_pkg::pi1_op_e             op_i,
	input  logic [soc_pkg::ADDR_BITS-1:0] addr_i,
	input  logic [soc_pkg::ARCH_BITS-1:0] data_i,
	output logic [soc_pkg::ARCH_BITS-1:0] data_o,
	output logic                         rst_req0_o,
	output logic                         rst_req1_o
);
	import soc_pkg::*;

	slave_idx_e slv;
	logic [15:0] dev_id;
	logic [ARCH_BITS-1:0] map_sz;
	logic in_table;
	logic ctrl_wr;

	// Two words per slave, id word then map size word
	assign slv = slave_idx_e'(addr_i[2:1]);
	assign in_table = addr_i < ADDR_BITS'(2 * SLAVE_COUNT);

	always_comb begin
		dev_id = '0;
		map_sz = '0;
		case (slv)
			SLV_INTCTRL: begin
				dev_id = 16'(DEVID_INTCTRL);
				map_sz = ARCH_BITS'(MAPSZ_INTCTRL);
			end
			SLV_DEVTBL: begin
				dev_id = 16'(DEVID_DEVTBL);
				map_sz = ARCH_BITS'(MAPSZ_DEVTBL);
			end
			SLV_RAM: begin
				dev_id = 16'(DEVID_RAM);
				map_sz = ARCH_BITS'(MAPSZ_RAM);
			end
			SLV_INVALID: begin
				dev_id = 16'(DEVID_INVALID);
				map_sz = ARCH_BITS'(MAPSZ_INVALID);
			end
		endcase
	end

	always_comb begin
		data_o = '0;
		if (in_table) begin
			if (addr_i[0]) begin
				data_o = map_sz;
			end else begin
				data_o = {USEINTR[slv], 15'b0, dev_id};
			end
		end
	end

	// Reset requests last only for the write cycle
	assign ctrl_wr = (op_i == PI1_WR || op_i == PI1_RDWR) &&
		(addr_i == ADDR_BITS'(DEVTBL_CTRL_WORD));
	assign rst_req0_o = ctrl_wr && data_i[0];
	assign rst_req1_o = ctrl_wr && data_i[1];

endmodule

//--- design/int_ctrl.sv
`timescale 1ns/1ps

module int_ctrl (
	input  logic                             clk48mhz_i,
	input  logic                             sys_rst_i,

	input  soc_pkg::pi1_op_e                 op_i,
	input  logic [soc_pkg::ADDR_BITS-1:0]     addr_i,
	input  logic [soc_pkg::ARCH_BITS-1:0]     data_i,
	output logic [soc_pkg::ARCH_BITS-1:0]     data_o,

	input  logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_i,
	output logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_ack_o,
	output logic                             int_rqst_o,
	input  logic                             int_ack_i
);
	import soc_pkg::*;

	ic_state_e state_q;
	logic [INT_IDX_BITS-1:0] cur_src_q;
	logic [INT_IDX_BITS-1:0] pick;
	logic [INT_SRC_COUNT-1:0] mask_q;
	logic [INT_SRC_COUNT-1:0] pending;
	logic reg_wr;

	assign pending = int_src_i & mask_q;
	assign reg_wr = op_i == PI1_WR || op_i == PI1_RDWR;

	// Lowest numbered pending source wins
	always_comb begin
		pick = '0;
		for (int k = INT_SRC_COUNT - 1; k >= 0; k--) begin
			if (pending[k]) begin
				pick = INT_IDX_BITS'(k);
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			state_q <= IC_IDLE;
			cur_src_q <= '0;
		end else begin
			case (state_q)
				IC_IDLE: begin
					if (pending != '0) begin
						state_q <= IC_DELIVER;
						cur_src_q <= pick;
					end
				end
				IC_DELIVER: begin
					// Wait for the destination to take it
					if (int_ack_i) begin
						state_q <= IC_ACK;
					end
				end
				IC_ACK: state_q <= IC_IDLE;
				default: state_q <= IC_IDLE;
			endcase
		end
	end

	// Enable mask at word 1
	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			mask_q <= '1;
		end else if (reg_wr && addr_i == ADDR_BITS'(1)) begin
			mask_q <= data_i[INT_SRC_COUNT-1:0];
		end
	end

	assign int_rqst_o = state_q == IC_DELIVER;

	// Source ack is a single cycle pulse out of IC_ACK
	always_comb begin
		int_src_ack_o = '0;
		if (state_q == IC_ACK) begin
			int_src_ack_o[cur_src_q] = 1'b1;
		end
	end

	always_comb begin
		data_o = '0;
		if (addr_i == ADDR_BITS'(0)) begin
			data_o = ARCH_BITS'(cur_src_q);
		end else if (addr_i == ADDR_BITS'(1)) begin
			data_o = ARCH_BITS'(mask_q);
		end
	end

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram (
	input  logic                            clk48mhz_i,
	input  soc_pkg::pi1_op_e                op_i,
	input  logic [soc_pkg::RAM_IDX_BITS-1:0] addr_i,
	input  logic [soc_pkg::ARCH_BITS-1:0]    data_i,
	input  logic [soc_pkg::SEL_BITS-1:0]     sel_i,
	output logic [soc_pkg::ARCH_BITS-1:0]    data_o
);
	import soc_pkg::*;

	logic [ARCH_BITS-1:0] mem [MAPSZ_RAM];
	logic wr_en;

	// Swap writes too, the old word goes out on data_o first
	assign wr_en = op_i == PI1_WR || op_i == PI1_RDWR;

	// Asynchronous read
	assign data_o = mem[addr_i];

	always_ff @(posedge clk48mhz_i) begin
		if (wr_en) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (sel_i[b]) begin
					mem[addr_i][8*b +: 8] <= data_i[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- design/pi1_soc_top.sv
`timescale 1ns/1ps

module pi1_soc_top (
	input  logic                             clk48mhz_i,
	input  logic                             rst_p,

	// Bus master port
	input  soc_pkg::pi1_op_e                 op_i,
	input  logic [soc_pkg::ADDR_BITS-1:0]     addr_i,
	input  logic [soc_pkg::ARCH_BITS-1:0]     data_i,
	input  logic [soc_pkg::SEL_BITS-1:0]      sel_i,
	output logic [soc_pkg::ARCH_BITS-1:0]     data_o,
	output logic                             rdy_o,

	// Interrupt sources and destination
	input  logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_i,
	output logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_ack_o,
	output logic                             int_rqst_o,
	input  logic                             int_ack_i,

	output logic                             sys_rst_o,
	output logic                             powered_off_o
);
	import soc_pkg::*;

	pi1_op_e intc_op;
	pi1_op_e devtbl_op;
	pi1_op_e ram_op;
	logic [ADDR_BITS-1:0] slv_addr;
	logic [ARCH_BITS-1:0] slv_data;
	logic [SEL_BITS-1:0] slv_sel;
	logic [ARCH_BITS-1:0] intc_data;
	logic [ARCH_BITS-1:0] devtbl_data;
	logic [ARCH_BITS-1:0] ram_data;
	logic rst_req0;
	logic rst_req1;

	reset_ctrl i_reset_ctrl (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.rst_req0_i    (rst_req0),
		.rst_req1_i    (rst_req1),
		.sys_rst_o     (sys_rst_o),
		.powered_off_o (powered_off_o)
	);

	pi1_router i_pi1_router (
		.sys_rst_i     (sys_rst_o),
		.op_i          (op_i),
		.addr_i        (addr_i),
		.data_i        (data_i),
		.sel_i         (sel_i),
		.data_o        (data_o),
		.rdy_o         (rdy_o),
		.intc_op_o     (intc_op),
		.devtbl_op_o   (devtbl_op),
		.ram_op_o      (ram_op),
		.slv_addr_o    (slv_addr),
		.slv_data_o    (slv_data),
		.slv_sel_o     (slv_sel),
		.intc_data_i   (intc_data),
		.devtbl_data_i (devtbl_data),
		.ram_data_i    (ram_data)
	);

	dev_table i_dev_table (
		.op_i       (devtbl_op),
		.addr_i     (slv_addr),
		.data_i     (slv_data),
		.data_o     (devtbl_data),
		.rst_req0_o (rst_req0),
		.rst_req1_o (rst_req1)
	);

	int_ctrl i_int_ctrl (
		.clk48mhz_i    (clk48mhz_i),
		.sys_rst_i     (sys_rst_o),
		.op_i          (intc_op),
		.addr_i        (slv_addr),
		.data_i        (slv_data),
		.data_o        (intc_data),
		.int_src_i     (int_src_i),
		.int_src_ack_o (int_src_ack_o),
		.int_rqst_o    (int_rqst_o),
		.int_ack_i     (int_ack_i)
	);

	// RAM offsets never exceed its map size, so the low bits suffice
	scratch_ram i_scratch_ram (
		.clk48mhz_i (clk48mhz_i),
		.op_i       (ram_op),
		.addr_i     (slv_addr[RAM_IDX_BITS-1:0]),
		.data_i     (slv_data),
		.sel_i      (slv_sel),
		.data_o     (ram_data)
	);

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
	end

	always begin
		#4;
		clk_o = ~clk_o;
	end

endmodule

//--- test/tb_pi1_soc.sv
`timescale 1ns/1ps

module tb_pi1_soc;
	import soc_pkg::*;

	// The tests take about 450 cycles
	localparam int CYCLE_LIMIT = 4000;
	localparam int RAM_WORDS = 64;

	logic clk;
	logic rst_p;
	pi1_op_e op;
	logic [ADDR_BITS-1:0] addr;
	logic [ARCH_BITS-1:0] wdata;
	logic [SEL_BITS-1:0] sel;
	logic [ARCH_BITS-1:0] rdata;
	logic rdy;
	logic [INT_SRC_COUNT-1:0] int_src;
	logic [INT_SRC_COUNT-1:0] int_src_ack;
	logic int_rqst;
	logic int_ack;
	logic sys_rst;
	logic powered_off;

	logic [31:0] seed = 32'd29894;
	logic [ARCH_BITS-1:0] ram_model [RAM_WORDS];
	int devid_exp [SLAVE_COUNT] = '{DEVID_INTCTRL, DEVID_DEVTBL, DEVID_RAM, DEVID_INVALID};
	int mapsz_exp [SLAVE_COUNT] = '{MAPSZ_INTCTRL, MAPSZ_DEVTBL, MAPSZ_RAM, MAPSZ_INVALID};
	int inv_addr [4] = '{BASE_INVALID, BASE_INVALID + MAPSZ_INVALID - 1,
		BASE_INVALID + MAPSZ_INVALID, 32'h3FFF_FFFF};
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int bad_tests = 0;
	int cycles = 0;
	int last_wait;

	tb_clk_gen i_clk_gen (
		.clk_o (clk)
	);

	pi1_soc_top i_pi1_soc_top (
		.clk48mhz_i    (clk),
		.rst_p         (rst_p),
		.op_i          (op),
		.addr_i        (addr),
		.data_i        (wdata),
		.sel_i         (sel),
		.data_o        (rdata),
		.rdy_o         (rdy),
		.int_src_i     (int_src),
		.int_src_ack_o (int_src_ack),
		.int_rqst_o    (int_rqst),
		.int_ack_i     (int_ack),
		.sys_rst_o     (sys_rst),
		.powered_off_o (powered_off)
	);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Byte lane merge as the bus defines it
	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] d, input logic [SEL_BITS-1:0] s);
		for (int b = 0; b < SEL_BITS; b++) begin
			if (s[b]) begin
				old[8*b +: 8] = d[8*b +: 8];
			end
		end
		return old;
	endfunction

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Fail at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Fail at %0d ns: %s, got %b, expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests++;
		if (errors == errs_at_start) begin
			$display("%s: done, no errors", name);
		end else begin
			bad_tests++;
			$display("%s: done, %0d errors", name, errors - errs_at_start);
		end
	endtask

	// Starts 1 ns after an edge and returns 1 ns after the edge that completes the access
	task automatic bus_access(input pi1_op_e o, input int a, input logic [31:0] d,
		input logic [SEL_BITS-1:0] s, output logic [31:0] r);
		op = o;
		addr = ADDR_BITS'(a);
		wdata = d;
		sel = s;
		last_wait = 0;
		#1;
		while (!rdy) begin
			@(posedge clk);
			#2;
			last_wait++;
		end
		r = rdata;
		@(posedge clk);
		#1;
		op = PI1_NOP;
	endtask

	task automatic bus_read(input int a, output logic [31:0] r);
		bus_access(PI1_RD, a, 32'd0, '0, r);
	endtask

	task automatic bus_write(input int a, input logic [31:0] d, input logic [SEL_BITS-1:0] s);
		logic [31:0] unused_r;
		bus_access(PI1_WR, a, d, s, unused_r);
	endtask

	// Counts the cycles with sys_rst_o high while the bus and interrupt outputs stay quiet
	task automatic measure_reset(output int n);
		n = 0;
		#1;
		while (sys_rst) begin
			n++;
			check_bit(rdy, 1'b0, "rdy_o during reset");
			check_bit(int_rqst, 1'b0, "int_rqst_o during reset");
			check_word(32'(int_src_ack), 32'd0, "int_src_ack_o during reset");
			@(posedge clk);
			#2;
		end
		// Sources and ack held across the stretch let go before the controller runs
		int_src = '0;
		int_ack = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic deliver_ack(input int k);
		int_ack = 1'b1;
		@(posedge clk);
		#1;
		int_ack = 1'b0;
		#1;
		check_word(32'(int_src_ack), 32'(1 << k), $sformatf("ack pulse of source %0d", k));
		@(posedge clk);
		#1;
		// Source drops its line once it has seen the ack
		int_src[k] = 1'b0;
		#1;
		check_word(32'(int_src_ack), 32'd0, "int_src_ack_o one cycle only");
		@(posedge clk);
		#1;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		int e0;
		int n;
		int a;
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] rnd;
		rst_p = 1'b1;
		op = PI1_NOP;
		addr = '0;
		wdata = '0;
		sel = '0;
		int_src = '0;
		int_ack = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_p = 1'b0;

		e0 = errors;
		@(posedge clk);
		#1;
		// Sources and ack stay active through the stretch
		int_src = '1;
		int_ack = 1'b1;
		measure_reset(n);
		check_word(32'(n), 32'(RST_STRETCH), "reset stretch after rst_p");
		end_test("Reset stretch", e0);

		e0 = errors;
		// Full words first so that every byte has a known value
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_model[i] = lcg_next();
			bus_write(BASE_RAM + i, ram_model[i], '1);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			a = int'(lcg_next() % 32'(RAM_WORDS));
			d = lcg_next();
			rnd = lcg_next();
			ram_model[a] = merge_bytes(ram_model[a], d, rnd[27:24]);
			bus_write(BASE_RAM + a, d, rnd[27:24]);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			bus_read(BASE_RAM + i, r);
			check_word(r, ram_model[i], $sformatf("RAM word %0d", i));
		end
		a = int'(lcg_next() % 32'(RAM_WORDS));
		d = lcg_next();
		rnd = lcg_next();
		bus_access(PI1_RDWR, BASE_RAM + a, d, rnd[27:24], r);
		check_word(r, ram_model[a], "old word returned by swap");
		ram_model[a] = merge_bytes(ram_model[a], d, rnd[27:24]);
		bus_read(BASE_RAM + a, r);
		check_word(r, ram_model[a], "word installed by swap");
		end_test("RAM access", e0);

		e0 = errors;
		for (int k = 0; k < SLAVE_COUNT; k++) begin
			bus_read(BASE_DEVTBL + 2 * k, r);
			check_word(r, {USEINTR[k], 15'd0, 16'(devid_exp[k])},
				$sformatf("id word of slave %0d", k));
			bus_read(BASE_DEVTBL + 2 * k + 1, r);
			check_word(r, 32'(mapsz_exp[k]), $sformatf("map size of slave %0d", k));
		end
		for (int w = 2 * SLAVE_COUNT; w < MAPSZ_DEVTBL; w++) begin
			bus_read(BASE_DEVTBL + w, r);
			check_word(r, 32'd0, $sformatf("unused table word %0d", w));
		end
		for (int i = 0; i < 4; i++) begin
			bus_read(inv_addr[i], r);
			check_word(r, 32'd0, $sformatf("invalid read at %h", inv_addr[i]));
			check_word(32'(last_wait), 32'd0, "wait states on invalid read");
		end
		// Offsets 0 and 1 alias RAM words in the low address bits
		bus_write(BASE_INVALID, 32'hFFFF_FFFF, '1);
		bus_write(BASE_INVALID + MAPSZ_INVALID + 1, 32'hFFFF_FFFF, '1);
		bus_read(BASE_RAM, r);
		check_word(r, ram_model[0], "RAM word 0 after invalid write");
		bus_read(BASE_RAM + 1, r);
		check_word(r, ram_model[1], "RAM word 1 after invalid write");
		bus_read(BASE_INVALID, r);
		check_word(r, 32'd0, "invalid read after write");
		end_test("Device table and invalid region", e0);

		e0 = errors;
		int_src = '1;
		@(posedge clk);
		#2;
		check_bit(int_rqst, 1'b1, "int_rqst_o one cycle after sources raised");
		@(posedge clk);
		#1;
		bus_read(BASE_INTCTRL, r);
		check_word(r, 32'd0, "index of first delivered source");
		deliver_ack(0);
		#1;
		check_bit(int_rqst, 1'b1, "int_rqst_o for source 1");
		@(posedge clk);
		#1;
		bus_read(BASE_INTCTRL, r);
		check_word(r, 32'd1, "index of second delivered source");
		deliver_ack(1);
		bus_write(BASE_INTCTRL + 1, 32'd1, '1);
		int_src[1] = 1'b1;
		repeat (8) begin
			@(posedge clk);
			#2;
			check_bit(int_rqst, 1'b0, "masked source 1 requested");
			check_word(32'(int_src_ack), 32'd0, "masked source 1 acked");
		end
		@(posedge clk);
		#1;
		bus_read(BASE_INTCTRL + 1, r);
		check_word(r, 32'd1, "mask after write");
		int_src[1] = 1'b0;
		end_test("Interrupt delivery", e0);

		e0 = errors;
		bus_write(BASE_DEVTBL + DEVTBL_CTRL_WORD, 32'd2, '1);
		measure_reset(n);
		check_word(32'(n), 32'(RST_STRETCH), "warm reset stretch");
		bus_read(BASE_INTCTRL + 1, r);
		check_word(r, (32'd1 << INT_SRC_COUNT) - 32'd1, "mask after warm reset");
		for (int i = 0; i < RAM_WORDS; i++) begin
			bus_read(BASE_RAM + i, r);
			check_word(r, ram_model[i], $sformatf("RAM word %0d after warm reset", i));
		end
		bus_write(BASE_DEVTBL + DEVTBL_CTRL_WORD, 32'd1, '1);
		repeat (2 * RST_STRETCH) begin
			#1;
			check_bit(powered_off, 1'b1, "powered_off_o after power-off write");
			check_bit(sys_rst, 1'b1, "sys_rst_o while powered off");
			check_bit(rdy, 1'b0, "rdy_o while powered off");
			@(posedge clk);
			#1;
		end
		rst_p = 1'b1;
		@(posedge clk);
		#2;
		check_bit(powered_off, 1'b0, "powered_off_o after rst_p");
		@(posedge clk);
		#1;
		rst_p = 1'b0;
		@(posedge clk);
		#1;
		measure_reset(n);
		check_word(32'(n), 32'(RST_STRETCH), "reset stretch after power-off");
		bus_read(BASE_RAM, r);
		check_word(r, ram_model[0], "RAM word 0 after power-off");
		end_test("Software resets", e0);

		$display("Tests: %0d, with errors: %0d, checks: %0d, failed checks: %0d",
			tests, bad_tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
design/soc_pkg.sv
design/reset_ctrl.sv
design/pi1_router.sv
design/dev_table.sv
design/int_ctrl.sv
design/scratch_ram.sv
design/pi1_soc_top.sv
test/tb_clk_gen.sv
test/tb_pi1_soc.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_pi1_soc \
	-f verilog.f \
	-o tb_pi1_soc_sim

./obj_dir/tb_pi1_soc_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "Failure reported, see sim.log"
	exit 1
fi

echo "No failure reported"
exit 0
